/* ctrl_pkg.sv */
package ctrl_pkg;

    localparam int ADDR_W    = 12;
    localparam int DIM_W     = 10;
    localparam int BUF_IDX_W = 2;
    localparam int LEN_W     = 12;

    localparam logic [LEN_W-1:0] WEIGHTS_LEN       = 12'd9;
    // Two extra beats when the filter parameters follow the weights
    localparam logic [LEN_W-1:0] WEIGHTS_PARAM_LEN = 12'd11;

    typedef enum logic [3:0] {
        LD_W = 4'h1,
        LD_D = 4'h2,
        SV_D = 4'h3,
        END  = 4'hf
    } opcode_e;

    // --------------------------------------------------------------------
    // Instruction words as written over APB
    // --------------------------------------------------------------------
    typedef struct packed {
        logic [13:0]          rsvd;
        logic [ADDR_W-1:0]    addr;
        logic [BUF_IDX_W-1:0] buf_idx;
        opcode_e              opcode;
    } word0_t;

    typedef struct packed {
        logic [11:0]      rsvd;
        logic [DIM_W-1:0] height;
        logic [DIM_W-1:0] width;
    } word1_t;

    typedef struct packed {
        logic [17:0]       rsvd;
        logic              prev_weights;
        logic              save_results;
        logic [ADDR_W-1:0] offset;
    } word2_t;

    typedef struct packed {
        word2_t w2;
        word1_t w1;
        word0_t w0;
    } raw_inst_t;

    // --------------------------------------------------------------------
    // Descriptors for the buffer reader and writer
    // --------------------------------------------------------------------
    typedef struct packed {
        logic [1:0]       rsvd;
        logic             activation;
        logic             save_results;
        logic [DIM_W-1:0] height;
        logic [DIM_W-1:0] width;
    } rd_header_t;

    typedef struct packed {
        logic [BUF_IDX_W-1:0] buf_idx;
        logic [ADDR_W-1:0]    addr;
        logic [LEN_W-1:0]     len;
        logic [DIM_W-1:0]     count;
        logic [ADDR_W-1:0]    offset;
        rd_header_t           header;
        logic                 header_valid;
        logic                 header_only;
    } rd_desc_t;

    typedef struct packed {
        logic [BUF_IDX_W-1:0] buf_idx;
        logic [ADDR_W-1:0]    addr;
        logic [LEN_W-1:0]     len;
        logic [DIM_W-1:0]     count;
        logic [ADDR_W-1:0]    offset;
    } wr_desc_t;

    localparam int RD_DESC_W = $bits(rd_desc_t);
    localparam int WR_DESC_W = $bits(wr_desc_t);

    // Write descriptors sit in the low bits of desc
    typedef struct packed {
        opcode_e              opcode;
        logic [RD_DESC_W-1:0] desc;
    } op_t;

    typedef enum logic [1:0] {
        WAIT_START,
        FETCH,
        RD,
        WR
    } issue_state_e;

endpackage

/* apb_inst_regs.sv */
module apb_inst_regs #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [3:0]                       paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output ctrl_pkg::raw_inst_t              inst,
    output logic                             inst_valid,
    input  logic                             inst_ready,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0] fill
);

    import ctrl_pkg::*;

    localparam logic [3:0] ADDR_WORD0  = 4'h0;
    localparam logic [3:0] ADDR_WORD1  = 4'h4;
    localparam logic [3:0] ADDR_WORD2  = 4'h8;
    localparam logic [3:0] ADDR_STATUS = 4'hc;

    raw_inst_t inst_q;
    logic      access;
    logic      mapped;
    logic      commit;

    assign access = psel && penable;
    assign mapped = paddr inside {ADDR_WORD0, ADDR_WORD1, ADDR_WORD2, ADDR_STATUS};
    assign commit = access && pwrite && (paddr == ADDR_WORD2);

    // Word 2 comes from the bus so the commit needs no extra cycle
    assign inst       = {pwdata, inst_q.w1, inst_q.w0};
    assign inst_valid = commit;

    // Wait states only while the queue is full
    assign pready  = !(commit && !inst_ready);
    assign pslverr = access && !mapped;

    always_comb begin
        case (paddr)
            ADDR_WORD0:  prdata = inst_q.w0;
            ADDR_WORD1:  prdata = inst_q.w1;
            ADDR_WORD2:  prdata = inst_q.w2;
            ADDR_STATUS: prdata = 32'(fill);
            default:     prdata = '0;
        endcase
    end

    // --------------------------------------------------------------------
    // Word registers
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_q <= '0;
        end else if (access && pwrite && pready) begin
            case (paddr)
                ADDR_WORD0: inst_q.w0 <= pwdata;
                ADDR_WORD1: inst_q.w1 <= pwdata;
                ADDR_WORD2: inst_q.w2 <= pwdata;
                default: ;
            endcase
        end
    end

endmodule

/* inst_queue.sv */
module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  ctrl_pkg::raw_inst_t              in_inst,
    input  logic                             in_valid,
    output logic                             in_ready,
    output ctrl_pkg::raw_inst_t              out_inst,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] fill
);

    import ctrl_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    raw_inst_t        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(QUEUE_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_inst  = mem[rd_ptr];
    assign fill      = count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_inst;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* inst_decoder.sv */
module inst_decoder (
    input  logic                clk,
    input  logic                reset,
    input  ctrl_pkg::raw_inst_t in_inst,
    input  logic                in_valid,
    output logic                in_ready,
    output ctrl_pkg::op_t       op,
    output logic                op_valid,
    input  logic                op_ready
);

    import ctrl_pkg::*;

    op_t      op_d;
    rd_desc_t rd;
    wr_desc_t wr;
    logic     known;

    always_comb begin
        rd         = '0;
        rd.buf_idx = in_inst.w0.buf_idx;
        rd.addr    = in_inst.w0.addr;

        wr.buf_idx = in_inst.w0.buf_idx;
        wr.addr    = in_inst.w0.addr;
        wr.len     = LEN_W'(in_inst.w1.width);
        wr.count   = in_inst.w1.height;
        wr.offset  = in_inst.w2.offset;

        op_d.opcode = in_inst.w0.opcode;
        op_d.desc   = '0;
        known       = 1'b1;

        case (in_inst.w0.opcode)
            LD_W: begin
                rd.len = in_inst.w2.save_results ? WEIGHTS_PARAM_LEN : WEIGHTS_LEN;
                rd.count = DIM_W'(1);
                rd.header.width = in_inst.w1.width;
                rd.header.height = in_inst.w1.height;
                rd.header.save_results = in_inst.w2.save_results;
                rd.header.activation = 1'b1;
                rd.header_valid = 1'b1;
                // Weights already in the buffer, only the header is sent
                rd.header_only = in_inst.w2.prev_weights;
                op_d.desc = rd;
            end
            LD_D: begin
                rd.len    = LEN_W'(in_inst.w1.width);
                rd.count  = in_inst.w1.height;
                rd.offset = in_inst.w2.offset;
                op_d.desc = rd;
            end
            SV_D: begin
                op_d.desc[WR_DESC_W-1:0] = wr;
            end
            END: ;
            default: known = 1'b0;
        endcase
    end

    assign in_ready = !op_valid || op_ready;

    // Unknown opcodes are consumed and dropped here
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (in_ready) begin
            op_valid <= in_valid && known;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op <= op_d;
        end
    end

endmodule

/* desc_issue.sv */
module desc_issue (
    input  logic               clk,
    input  logic               reset,
    input  ctrl_pkg::op_t      op,
    input  logic               op_valid,
    output logic               op_ready,
    input  logic               start,
    output logic               done,
    output ctrl_pkg::rd_desc_t rd_desc,
    output logic               rd_valid,
    input  logic               rd_ack,
    output ctrl_pkg::wr_desc_t wr_desc,
    output logic               wr_valid,
    input  logic               wr_ack
);

    import ctrl_pkg::*;

    issue_state_e state;
    issue_state_e state_next;
    logic         take;
    logic         load_rd;
    logic         load_wr;

    assign op_ready = (state == FETCH);
    assign take     = op_valid && op_ready;
    assign load_rd  = take && (state_next == RD);
    assign load_wr  = take && (state_next == WR);

    assign rd_valid = (state == RD);
    assign wr_valid = (state == WR);

    // --------------------------------------------------------------------
    // Sequencer
    // --------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            WAIT_START: begin
                if (start) begin
                    state_next = FETCH;
                end
            end
            FETCH: begin
                if (take) begin
                    case (op.opcode)
                        LD_W, LD_D: state_next = RD;
                        SV_D:       state_next = WR;
                        END:        state_next = WAIT_START;
                        default:    state_next = FETCH;
                    endcase
                end
            end
            RD: begin
                if (rd_ack) begin
                    state_next = FETCH;
                end
            end
            WR: begin
                if (wr_ack) begin
                    state_next = FETCH;
                end
            end
            default: state_next = WAIT_START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WAIT_START;
        end else begin
            state <= state_next;
        end
    end

    // Held until the next start
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (state == WAIT_START && start) begin
            done <= 1'b0;
        end else if (take && op.opcode == END) begin
            done <= 1'b1;
        end
    end

    // --------------------------------------------------------------------
    // Descriptor registers
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_rd) begin
            rd_desc <= op.desc;
        end
        if (load_wr) begin
            wr_desc <= op.desc[WR_DESC_W-1:0];
        end
    end

endmodule

/* accel_ctrl_top.sv */
module accel_ctrl_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               start,
    output logic               done,
    output ctrl_pkg::rd_desc_t rd_desc,
    output logic               rd_valid,
    input  logic               rd_ack,
    output ctrl_pkg::wr_desc_t wr_desc,
    output logic               wr_valid,
    input  logic               wr_ack
);

    import ctrl_pkg::*;

    raw_inst_t                        apb_inst;
    logic                             apb_valid;
    logic                             apb_ready;
    raw_inst_t                        q_inst;
    logic                             q_valid;
    logic                             q_ready;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] fill;
    op_t                              dec_op;
    logic                             dec_valid;
    logic                             dec_ready;

    // APB capture, queue, decode, issue
    apb_inst_regs #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_apb (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .inst(apb_inst), .inst_valid(apb_valid), .inst_ready(apb_ready),
        .fill(fill)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .reset(reset),
        .in_inst(apb_inst), .in_valid(apb_valid), .in_ready(apb_ready),
        .out_inst(q_inst), .out_valid(q_valid), .out_ready(q_ready),
        .fill(fill)
    );

    inst_decoder u_decoder (
        .clk(clk), .reset(reset),
        .in_inst(q_inst), .in_valid(q_valid), .in_ready(q_ready),
        .op(dec_op), .op_valid(dec_valid), .op_ready(dec_ready)
    );

    desc_issue u_issue (
        .clk(clk), .reset(reset),
        .op(dec_op), .op_valid(dec_valid), .op_ready(dec_ready),
        .start(start), .done(done),
        .rd_desc(rd_desc), .rd_valid(rd_valid), .rd_ack(rd_ack),
        .wr_desc(wr_desc), .wr_valid(wr_valid), .wr_ack(wr_ack)
    );

endmodule

/* accel_ctrl_assert.sv */
module accel_ctrl_assert (
    input logic               clk,
    input logic               reset,
    input logic               psel,
    input logic               penable,
    input logic [3:0]         paddr,
    input logic               pready,
    input logic               pslverr,
    input logic               start,
    input logic               done,
    input ctrl_pkg::rd_desc_t rd_desc,
    input logic               rd_valid,
    input logic               rd_ack,
    input ctrl_pkg::wr_desc_t wr_desc,
    input logic               wr_valid,
    input logic               wr_ack
);

    logic mapped;
    int   fail_count = 0;

    assign mapped = paddr inside {4'h0, 4'h4, 4'h8, 4'hc};

    // ----------------------------------------------------------------------
    // Reset and control
    // ----------------------------------------------------------------------
    assert property (@(posedge clk) $fell(reset) |-> !rd_valid && !wr_valid && !done && pready)
        else begin fail_count++; $error("Outputs not idle after reset"); end

    assert property (@(posedge clk) disable iff (reset) start |=> !done)
        else begin fail_count++; $error("done still high after start"); end

    assert property (@(posedge clk) disable iff (reset) done |-> !rd_valid && !wr_valid)
        else begin fail_count++; $error("Descriptor issued while done"); end

    assert property (@(posedge clk) disable iff (reset) pslverr == (psel && penable && !mapped))
        else begin fail_count++; $error("pslverr does not match the address map"); end

    // ----------------------------------------------------------------------
    // Descriptor channels
    // ----------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (reset)
        rd_valid && !rd_ack |=> rd_valid && $stable(rd_desc))
        else begin fail_count++; $error("Read descriptor dropped or changed before ack"); end

    assert property (@(posedge clk) disable iff (reset)
        wr_valid && !wr_ack |=> wr_valid && $stable(wr_desc))
        else begin fail_count++; $error("Write descriptor dropped or changed before ack"); end

    assert property (@(posedge clk) disable iff (reset) rd_valid && rd_ack |=> !rd_valid)
        else begin fail_count++; $error("rd_valid high after ack"); end

    assert property (@(posedge clk) disable iff (reset) wr_valid && wr_ack |=> !wr_valid)
        else begin fail_count++; $error("wr_valid high after ack"); end

endmodule

bind accel_ctrl_top accel_ctrl_assert u_assert (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .paddr(paddr),
    .pready(pready), .pslverr(pslverr), .start(start), .done(done),
    .rd_desc(rd_desc), .rd_valid(rd_valid), .rd_ack(rd_ack),
    .wr_desc(wr_desc), .wr_valid(wr_valid), .wr_ack(wr_ack)
);

/* tb_accel_ctrl.sv */
module tb_accel_ctrl;

    import ctrl_pkg::*;

    localparam int PERIOD         = 40;
    localparam int QUEUE_DEPTH    = 4;
    localparam int NUM_INSTS      = 24;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * (12 + 12) + 400;

    typedef struct packed {
        logic     is_wr;
        rd_desc_t rd;
        wr_desc_t wr;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        start;
    logic        done;
    rd_desc_t    rd_desc;
    logic        rd_valid;
    logic        rd_ack;
    wr_desc_t    wr_desc;
    logic        wr_valid;
    logic        wr_ack;

    logic [15:0] lfsr;
    raw_inst_t   insts [NUM_INSTS];
    logic [2:0]  ack_delays [32];
    expect_t     exp_q [$];
    int          head_count;
    int          sb_idx = 0;
    int          cycles;

    accel_ctrl_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [3:0] pick_code();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    return LD_W;
            2'd1:    return LD_D;
            2'd2:    return SV_D;
            default: return 4'h4 + 4'(rand_bits(2));
        endcase
    endfunction

    function automatic raw_inst_t make_inst(input logic [3:0] code);
        raw_inst_t inst;
        inst                 = '0;
        inst.w0.opcode       = opcode_e'(code);
        inst.w0.buf_idx      = BUF_IDX_W'(rand_bits(BUF_IDX_W));
        inst.w0.addr         = ADDR_W'(rand_bits(ADDR_W));
        inst.w1.width        = DIM_W'(rand_bits(DIM_W));
        inst.w1.height       = DIM_W'(rand_bits(DIM_W));
        inst.w2.offset       = ADDR_W'(rand_bits(ADDR_W));
        inst.w2.save_results = 1'(rand_bits(1));
        inst.w2.prev_weights = 1'(rand_bits(1));
        return inst;
    endfunction

    // ----------------------------------------------------------------------
    // Expected descriptors from the decode rules
    // ----------------------------------------------------------------------
    function automatic void add_expected(input raw_inst_t inst);
        expect_t e;
        e = '0;
        case (inst.w0.opcode)
            LD_W: begin
                e.rd.buf_idx             = inst.w0.buf_idx;
                e.rd.addr                = inst.w0.addr;
                e.rd.len                 = inst.w2.save_results ? 12'd11 : 12'd9;
                e.rd.count               = 10'd1;
                e.rd.header.width        = inst.w1.width;
                e.rd.header.height       = inst.w1.height;
                e.rd.header.save_results = inst.w2.save_results;
                e.rd.header.activation   = 1'b1;
                e.rd.header_valid        = 1'b1;
                e.rd.header_only         = inst.w2.prev_weights;
                exp_q.push_back(e);
            end
            LD_D: begin
                e.rd.buf_idx = inst.w0.buf_idx;
                e.rd.addr    = inst.w0.addr;
                e.rd.len     = 12'(inst.w1.width);
                e.rd.count   = inst.w1.height;
                e.rd.offset  = inst.w2.offset;
                exp_q.push_back(e);
            end
            SV_D: begin
                e.is_wr      = 1'b1;
                e.wr.buf_idx = inst.w0.buf_idx;
                e.wr.addr    = inst.w0.addr;
                e.wr.len     = 12'(inst.w1.width);
                e.wr.count   = inst.w1.height;
                e.wr.offset  = inst.w2.offset;
                exp_q.push_back(e);
            end
            default: ;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // APB driver, ready sampled mid low phase
    // ----------------------------------------------------------------------
    task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        logic ready;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        ready   = 1'b0;
        while (!ready) begin
            #(PERIOD / 4);
            ready = pready;
            rdata = prdata;
            err   = pslverr;
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_inst(input raw_inst_t inst);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, 4'h0, inst.w0, rdata, err);
        apb_xfer(1'b1, 4'h4, inst.w1, rdata, err);
        apb_xfer(1'b1, 4'h8, inst.w2, rdata, err);
    endtask

    task automatic score(input logic is_wr, input logic [127:0] got, input string name);
        expect_t e;
        if (sb_idx >= exp_q.size()) begin
            fail_run($sformatf("Unexpected %s handshake, no descriptor was expected", name));
        end else begin
            e = exp_q[sb_idx];
            sb_idx++;
            if (e.is_wr != is_wr) begin
                fail_run($sformatf("%s handshake arrived on the wrong channel", name));
            end else if (is_wr) begin
                expect_equal(name, got, 128'(e.wr));
            end else begin
                expect_equal(name, got, 128'(e.rd));
            end
        end
    endtask

    // Ack after the drawn delay, dropped again after the handshake
    task automatic respond(input logic valid, inout logic ack, inout logic [3:0] delay,
                           inout int n);
        if (ack || !valid) begin
            ack   = 1'b0;
            delay = 4'hf;
        end else begin
            if (delay == 4'hf) begin
                delay = {1'b0, ack_delays[n % 32]};
                n++;
            end else begin
                delay = delay - 4'd1;
            end
            ack = (delay == 4'd0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        logic [3:0] rd_delay;
        logic [3:0] wr_delay;
        int         rd_n;
        int         wr_n;
        rd_ack   = 1'b0;
        wr_ack   = 1'b0;
        rd_delay = 4'hf;
        wr_delay = 4'hf;
        rd_n     = 0;
        wr_n     = 0;
        forever begin
            @(negedge clk);
            respond(rd_valid, rd_ack, rd_delay, rd_n);
            respond(wr_valid, wr_ack, wr_delay, wr_n);
        end
    end

    always @(posedge clk) begin
        if (rd_valid && rd_ack) begin
            score(1'b0, 128'(rd_desc), "rd_desc");
        end
        if (wr_valid && wr_ack) begin
            score(1'b1, 128'(wr_desc), "wr_desc");
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(negedge clk);
            cycles++;
            if (uut.u_assert.fail_count != 0) begin
                fail_run("A protocol assertion failed");
            end else if (cycles >= TIMEOUT_CYCLES) begin
                fail_run("Timeout: the instruction stream did not finish");
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int          i;
        logic [3:0]  code;
        logic [31:0] rdata;
        logic        err;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = 32'h0;
        start   = 1'b0;
        lfsr    = 16'd68;
        for (i = 0; i < NUM_INSTS; i++) begin
            case (i)
                0, 1:    code = LD_W;
                2, 4:    code = LD_D;
                3, 5:    code = SV_D;
                8:       code = 4'h9;
                19:      code = 4'h0;
                17, 23:  code = END;
                default: code = pick_code();
            endcase
            insts[i] = make_inst(code);
        end
        // Both weight lengths and both header_only values
        insts[0].w2.save_results = 1'b0;
        insts[0].w2.prev_weights = 1'b1;
        insts[1].w2.save_results = 1'b1;
        insts[1].w2.prev_weights = 1'b0;
        for (i = 0; i < NUM_INSTS; i++) begin
            add_expected(insts[i]);
            if (i == 17) begin
                head_count = exp_q.size();
            end
        end
        for (i = 0; i < 32; i++) begin
            ack_delays[i] = 3'(rand_bits(3));
        end

        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Fill the queue before start, one more sits in the decoder
        for (i = 0; i < 5; i++) begin
            send_inst(insts[i]);
        end
        apb_xfer(1'b0, 4'hc, 32'h0, rdata, err);
        expect_equal("prdata", 128'(rdata), 128'(QUEUE_DEPTH));
        apb_xfer(1'b1, 4'h5, 32'hffff_ffff, rdata, err);
        expect_equal("pslverr", 128'(err), 128'(1));
        fork
            send_inst(insts[5]);
            begin
                repeat (10) @(negedge clk);
                #(PERIOD / 4);
                expect_equal("pready", 128'(pready), 128'(0));
                @(negedge clk);
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
        join

        for (i = 6; i <= 17; i++) begin
            send_inst(insts[i]);
        end
        while (!done) begin
            @(negedge clk);
        end

        // Queued behind END, nothing may issue before the next start
        for (i = 18; i <= 22; i++) begin
            send_inst(insts[i]);
        end
        repeat (20) @(negedge clk);
        expect_equal("done", 128'(done), 128'(1));
        expect_equal("descriptor count", 128'(sb_idx), 128'(head_count));
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        send_inst(insts[23]);
        while (!done) begin
            @(negedge clk);
        end

        if (sb_idx == exp_q.size()) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("Not every expected descriptor was issued");
        end
    end

endmodule

/* project.f */
ctrl_pkg.sv
apb_inst_regs.sv
inst_queue.sv
inst_decoder.sv
desc_issue.sv
accel_ctrl_top.sv
accel_ctrl_assert.sv
tb_accel_ctrl.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_accel_ctrl -o sim_accel_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_accel_ctrl)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
